//--- depth_acc.f
tm_cfg_pkg.sv
tm_msg_pkg.sv
depth_init_ctrl.sv
depth_req_fifo.sv
depth_ram.sv
depth_level.sv
depth_acc.sv
depth_acc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the depth accumulator testbench with Verilator and runs it.
# The exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module depth_acc_tb -f depth_acc.f -o sim_depth_acc \
	|| { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/sim_depth_acc)"
status=$?
echo "$out"

[ "$status" -eq 0 ] \
	&& echo "$out" | grep -q "^Simulation PASSED$" \
	&& exit 0 \
	|| { echo "Run did not pass"; exit 1; }

//--- depth_acc_tb.sv
// Testbench for the depth accumulator: stimulus, reference model and ack checks.
module depth_acc_tb import tm_cfg_pkg::*, tm_msg_pkg::*; ();

	localparam int QN          = 1 << QID_W_DEF;
	localparam int CN          = 1 << CID_W_DEF;
	localparam int INIT_CYCLES = QN + 1;
	localparam int MAX_CYCLES  = QN + 6000;
	localparam int RAND_CYCLES = 3000;

	typedef logic [QID_W_DEF-1:0] qid_t;
	typedef logic [CID_W_DEF-1:0] cid_t;

	// One outstanding request and the depth it has to return.
	typedef struct packed {
		qid_t   id;
		depth_t depth;
	} exp_t;

	logic       clk;
	logic       arst_n;
	logic       queue_req;
	qid_t       queue_id;
	logic       conn_req;
	cid_t       conn_id;
	logic       deq_req;
	qid_t       deq_qid;
	cid_t       deq_cid;
	depth_rsp_t queue_rsp;
	depth_rsp_t conn_rsp;
	logic       init_done;

	// Reference model with counts per id, requests still waiting per id and expected acks in order.
	depth_t q_cnt [QN];
	depth_t c_cnt [CN];
	int     q_pend [QN];
	int     c_pend [CN];
	exp_t   q_exp [$];
	exp_t   c_exp [$];

	int    value_errors = 0;
	int    proto_errors = 0;
	int    cycle_cnt = 0;
	string test_name = "init";

	depth_acc dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.queue_req (queue_req),
		.queue_id  (queue_id),
		.conn_req  (conn_req),
		.conn_id   (conn_id),
		.deq_req   (deq_req),
		.deq_qid   (deq_qid),
		.deq_cid   (deq_cid),
		.queue_rsp (queue_rsp),
		.conn_rsp  (conn_rsp),
		.init_done (init_done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Run limit counted in rising edges.
	initial begin
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
		$display("Simulation FAILED");
		$finish;
	end

	// One cycle of stimulus; the model applies the dequeue before the requests.
	task automatic drive_cycle(input logic qr, input qid_t qid, input logic cr, input cid_t cid,
		input logic dq, input qid_t dqid, input cid_t dcid);
		exp_t e;
		@(posedge clk);
		queue_req <= qr;
		queue_id  <= qid;
		conn_req  <= cr;
		conn_id   <= cid;
		deq_req   <= dq;
		deq_qid   <= dqid;
		deq_cid   <= dcid;
		if (dq) begin
			q_cnt[dqid] = q_cnt[dqid] - depth_t'(1);
			c_cnt[dcid] = c_cnt[dcid] - depth_t'(1);
		end
		if (qr) begin
			e.id    = qid;
			e.depth = q_cnt[qid];
			q_exp.push_back(e);
			q_cnt[qid]  = q_cnt[qid] + depth_t'(1);
			q_pend[qid] = q_pend[qid] + 1;
		end
		if (cr) begin
			e.id    = qid_t'(cid);
			e.depth = c_cnt[cid];
			c_exp.push_back(e);
			c_cnt[cid]  = c_cnt[cid] + depth_t'(1);
			c_pend[cid] = c_pend[cid] + 1;
		end
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
	endtask

	// Issues n requests to one queue id and one connection id.
	// A new request goes out as soon as fewer than two are unanswered on each level.
	task automatic req_burst(input qid_t qid, input cid_t cid, input int n);
		for (int i = 0; i < n; i++) begin
			while (q_exp.size() >= 2 || c_exp.size() >= 2) begin
				idle_cycle();
			end
			drive_cycle(1'b1, qid, 1'b1, cid, 1'b0, '0, '0);
		end
	endtask

	// Idles until every expected ack has arrived, then a few more cycles.
	task automatic wait_drained();
		while (q_exp.size() != 0 || c_exp.size() != 0) begin
			idle_cycle();
		end
		repeat (3) idle_cycle();
	endtask

	// Acks are checked on the falling edge, away from the DUT's own updates.
	always @(negedge clk) begin : check_acks
		exp_t e;
		if (arst_n) begin
			assert (init_done || (!queue_rsp.ack && !conn_rsp.ack)) else begin
				$display("An ack appeared before init_done was high");
				proto_errors++;
			end
			if (queue_rsp.ack) begin
				assert (q_exp.size() != 0) else begin
					$display("Queue level acked with no request outstanding (%s)", test_name);
					proto_errors++;
				end
				if (q_exp.size() != 0) begin
					e = q_exp.pop_front();
					q_pend[e.id] = q_pend[e.id] - 1;
					assert (queue_rsp.depth == e.depth) else begin
						$display("FAIL %s queue id %0d expected %0d actual %0d",
							test_name, e.id, e.depth, queue_rsp.depth);
						value_errors++;
					end
				end
			end
			if (conn_rsp.ack) begin
				assert (c_exp.size() != 0) else begin
					$display("Connection level acked with no request outstanding (%s)", test_name);
					proto_errors++;
				end
				if (c_exp.size() != 0) begin
					e = c_exp.pop_front();
					c_pend[e.id[CID_W_DEF-1:0]] = c_pend[e.id[CID_W_DEF-1:0]] - 1;
					assert (conn_rsp.depth == e.depth) else begin
						$display("FAIL %s conn id %0d expected %0d actual %0d",
							test_name, e.id, e.depth, conn_rsp.depth);
						value_errors++;
					end
				end
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic        qr;
		logic        cr;
		logic        dq;
		qid_t        qid;
		qid_t        dqid;
		cid_t        cid;
		cid_t        dcid;
		int          rel_cycle;
		int          init_cycles;

		void'($urandom(51560));
		arst_n    <= 1'b0;
		queue_req <= 1'b0;
		queue_id  <= '0;
		conn_req  <= 1'b0;
		conn_id   <= '0;
		deq_req   <= 1'b0;
		deq_qid   <= '0;
		deq_cid   <= '0;
		for (int i = 0; i < QN; i++) begin
			q_cnt[i]  = '0;
			q_pend[i] = 0;
		end
		for (int i = 0; i < CN; i++) begin
			c_cnt[i]  = '0;
			c_pend[i] = 0;
		end

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		rel_cycle = cycle_cnt;

		// Requests while the memories are cleared must be dropped.
		@(posedge clk);
		queue_req <= 1'b1;
		queue_id  <= qid_t'(3);
		conn_req  <= 1'b1;
		conn_id   <= cid_t'(2);
		@(posedge clk);
		queue_req <= 1'b0;
		conn_req  <= 1'b0;
		@(negedge clk);
		while (!init_done) @(negedge clk);
		init_cycles = cycle_cnt - rel_cycle;
		assert (init_cycles == INIT_CYCLES) else begin
			$display("init_done rose %0d cycles after reset, expected %0d",
				init_cycles, INIT_CYCLES);
			proto_errors++;
		end
		repeat (4) idle_cycle();

		test_name = "first_req";
		drive_cycle(1'b1, qid_t'(5), 1'b1, cid_t'(3), 1'b0, '0, '0);
		drive_cycle(1'b1, qid_t'(63), 1'b0, '0, 1'b0, '0, '0);
		wait_drained();

		// Same-id requests in consecutive cycles, so each second read depends on a write in flight.
		test_name = "back_to_back";
		req_burst(qid_t'(9), cid_t'(7), 6);
		wait_drained();

		test_name = "deq_count";
		req_burst(qid_t'(20), cid_t'(11), 5);
		wait_drained();
		repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, qid_t'(20), cid_t'(11));
		drive_cycle(1'b1, qid_t'(20), 1'b1, cid_t'(11), 1'b1, qid_t'(9), cid_t'(7));
		drive_cycle(1'b1, qid_t'(9), 1'b1, cid_t'(7), 1'b0, '0, '0);
		wait_drained();

		test_name = "random";
		for (int n = 0; n < RAND_CYCLES; n++) begin
			r    = $urandom();
			qr   = r[0] && (q_exp.size() < 2);
			cr   = r[1] && (c_exp.size() < 2);
			qid  = r[7:2];
			cid  = r[11:8];
			dqid = r[17:12];
			dcid = r[21:18];
			dq   = (r[23:22] != 2'b00) && (q_cnt[dqid] != '0) && (c_cnt[dcid] != '0)
				&& (q_pend[dqid] == 0) && (c_pend[dcid] == 0);
			drive_cycle(qr, qid, cr, cid, dq, dqid, dcid);
		end
		wait_drained();

		$display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- depth_acc.sv
// Top level depth accumulator: init control plus queue and connection levels.
module depth_acc import tm_cfg_pkg::*, tm_msg_pkg::*; #(
	parameter int QID_W = QID_W_DEF,
	parameter int CID_W = CID_W_DEF
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             queue_req,
	input  logic [QID_W-1:0] queue_id,
	input  logic             conn_req,
	input  logic [CID_W-1:0] conn_id,
	input  logic             deq_req,
	input  logic [QID_W-1:0] deq_qid,
	input  logic [CID_W-1:0] deq_cid,
	output depth_rsp_t       queue_rsp,
	output depth_rsp_t       conn_rsp,
	output logic             init_done
);

	// Init walks the wider of the two id spaces.
	localparam int INIT_W = (QID_W > CID_W) ? QID_W : CID_W;

	typedef logic [QID_W-1:0] qid_t;
	typedef logic [CID_W-1:0] cid_t;

	init_wr_t init_wr;

	depth_init_ctrl #(
		.ADDR_W(INIT_W)
	) u_init_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.init_wr   (init_wr),
		.init_done (init_done)
	);

	// Queue level.
	depth_level #(
		.id_t(qid_t)
	) u_queue_lvl (
		.clk       (clk),
		.arst_n    (arst_n),
		.init_wr   (init_wr),
		.init_done (init_done),
		.req       (queue_req),
		.req_id    (queue_id),
		.deq       (deq_req),
		.deq_id    (deq_qid),
		.rsp       (queue_rsp)
	);

	// Connection level, sharing the dequeue strobe.
	depth_level #(
		.id_t(cid_t)
	) u_conn_lvl (
		.clk       (clk),
		.arst_n    (arst_n),
		.init_wr   (init_wr),
		.init_done (init_done),
		.req       (conn_req),
		.req_id    (conn_id),
		.deq       (deq_req),
		.deq_id    (deq_cid),
		.rsp       (conn_rsp)
	);

endmodule

//--- depth_level.sv
// One depth level: arbitration, read-modify-write pipeline, forwarding and response.
module depth_level import tm_cfg_pkg::*, tm_msg_pkg::*; #(
	parameter type id_t = logic [QID_W_DEF-1:0]
) (
	input  logic       clk,
	input  logic       arst_n,
	input  init_wr_t   init_wr,
	input  logic       init_done,
	input  logic       req,
	input  id_t        req_id,
	input  logic       deq,
	input  id_t        deq_id,
	output depth_rsp_t rsp
);

	// Sampled inputs.
	logic req_d1;
	id_t  req_id_d1;
	logic deq_d1;
	id_t  deq_id_d1;

	// Pending request FIFO.
	logic fifo_pop;
	logic fifo_empty;
	id_t  fifo_head;

	// Stage 0, memory read address.
	logic s0_valid;
	id_t  s0_id;

	// Stage 1, memory data and forwarding.
	logic   s1_valid;
	logic   s1_deq;
	id_t    s1_id;
	depth_t ram_rdata;
	depth_t s1_old;

	// Stage 2, the write in flight and the one that landed last cycle.
	logic   wr_en;
	id_t    wr_id;
	depth_t wr_data;
	logic   wr_en_d1;
	id_t    wr_id_d1;
	depth_t wr_data_d1;

	// Memory write port after the init override.
	logic   ram_we;
	id_t    ram_waddr;
	depth_t ram_wdata;

	logic   rsp_ack;
	depth_t rsp_depth;

	// Nothing is taken in until the memory has been cleared.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_d1 <= 1'b0;
			deq_d1 <= 1'b0;
		end else begin
			req_d1 <= req & init_done;
			deq_d1 <= deq & init_done;
		end
	end

	always_ff @(posedge clk) begin
		req_id_d1 <= req_id;
		deq_id_d1 <= deq_id;
	end

	depth_req_fifo #(
		.id_t(id_t)
	) u_req_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.push    (req_d1),
		.push_id (req_id_d1),
		.pop     (fifo_pop),
		.head_id (fifo_head),
		.empty   (fifo_empty)
	);

	// Dequeue always wins the memory slot; a pending request waits behind it.
	assign fifo_pop = ~deq_d1 & ~fifo_empty & init_done;
	assign s0_valid = deq_d1 | fifo_pop;
	assign s0_id    = deq_d1 ? deq_id_d1 : fifo_head;

	depth_ram #(
		.id_t   (id_t),
		.data_t (depth_t)
	) u_depth_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (s0_id),
		.rdata (ram_rdata)
	);

	// Newest write first: the one about to land, then the one that just landed.
	always_comb begin
		if (wr_en && (wr_id == s1_id)) begin
			s1_old = wr_data;
		end else if (wr_en_d1 && (wr_id_d1 == s1_id)) begin
			s1_old = wr_data_d1;
		end else begin
			s1_old = ram_rdata;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			s1_deq   <= 1'b0;
			wr_en    <= 1'b0;
			wr_en_d1 <= 1'b0;
			rsp_ack  <= 1'b0;
		end else begin
			s1_valid <= s0_valid;
			s1_deq   <= deq_d1;
			wr_en    <= s1_valid;
			wr_en_d1 <= wr_en;
			rsp_ack  <= s1_valid & ~s1_deq;
		end
	end

	// Counts wrap, so no saturation on either side.
	always_ff @(posedge clk) begin
		s1_id      <= s0_id;
		wr_id      <= s1_id;
		wr_data    <= s1_deq ? (s1_old - depth_t'(1)) : (s1_old + depth_t'(1));
		wr_id_d1   <= wr_id;
		wr_data_d1 <= wr_data;
		if (s1_valid && !s1_deq) begin
			rsp_depth <= s1_old;
		end
	end

	// Init clearing owns the write port while it runs.
	assign ram_we    = init_wr.en | wr_en;
	assign ram_waddr = init_wr.en ? id_t'(init_wr.addr) : wr_id;
	assign ram_wdata = init_wr.en ? '0 : wr_data;

	assign rsp = '{ack: rsp_ack, depth: rsp_depth};

endmodule

//--- depth_ram.sv
// Synchronous one-read one-write depth memory with a registered read port.
module depth_ram #(
	parameter type id_t   = logic [5:0],
	parameter type data_t = logic [7:0]
) (
	input  logic  clk,
	input  logic  we,
	input  id_t   waddr,
	input  data_t wdata,
	input  id_t   raddr,
	output data_t rdata
);

	localparam int ENTRIES = 2 ** $bits(id_t);

	data_t mem [ENTRIES];

	// A read at the same address as a write in the same cycle returns the old data.
	// The level pipeline forwards around that.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

//--- depth_req_fifo.sv
// Two-entry pending request FIFO holding ids while dequeues use the memory.
module depth_req_fifo import tm_cfg_pkg::*; #(
	parameter type id_t = logic [QID_W_DEF-1:0]
) (
	input  logic clk,
	input  logic arst_n,
	input  logic push,
	input  id_t  push_id,
	input  logic pop,
	output id_t  head_id,
	output logic empty
);

	id_t slot [2];
	logic rd_ptr;
	logic wr_ptr;
	logic [1:0] count;

	// Entry storage.
	always_ff @(posedge clk) begin
		if (push) begin
			slot[wr_ptr] <= push_id;
		end
	end

	// Pointers and occupancy.
	// The caller never pushes into a full FIFO and the level never pops an empty one.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_ptr <= 1'b0;
			wr_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			case ({push, pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	// Head is visible without a read strobe.
	assign head_id = slot[rd_ptr];
	assign empty   = (count == 2'd0);

endmodule

//--- depth_init_ctrl.sv
// Init FSM and address counter that clear both depth memories after reset.
module depth_init_ctrl import tm_cfg_pkg::*, tm_msg_pkg::*; #(
	parameter int ADDR_W = QID_W_DEF
) (
	input  logic     clk,
	input  logic     arst_n,
	output init_wr_t init_wr,
	output logic     init_done
);

	typedef enum logic [1:0] {
		st_idle,
		st_clear,
		st_done
	} state_t;

	state_t state;
	state_t state_nxt;
	logic [ADDR_W-1:0] addr_cnt;

	// Idle lasts one cycle, clear walks every address once, done is terminal.
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:  state_nxt = st_clear;
			st_clear: begin
				if (&addr_cnt) begin
					state_nxt = st_done;
				end
			end
			st_done:  state_nxt = st_done;
			default:  state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			addr_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_clear) begin
				addr_cnt <= addr_cnt + 1'b1;
			end
		end
	end

	// Write enable is high for exactly 2**ADDR_W cycles.
	assign init_wr.en   = (state == st_clear);
	assign init_wr.addr = QID_W_DEF'(addr_cnt);
	assign init_done    = (state == st_done);

endmodule

//--- tm_msg_pkg.sv
// Message package: depth response and init write structs.
package tm_msg_pkg;

	import tm_cfg_pkg::*;

	// Response of one level to a depth request.
	// The ack bit is a one-cycle pulse; depth holds the count
	// the id had before the request was applied.
	typedef struct packed {
		logic   ack;
		depth_t depth;
	} depth_rsp_t;

	// Init write broadcast to every level while the memories are cleared.
	// The address spans the widest level; narrower levels keep the low bits.
	typedef struct packed {
		logic                 en;
		logic [QID_W_DEF-1:0] addr;
	} init_wr_t;

endpackage

//--- tm_cfg_pkg.sv
// Configuration package: depth width, default id widths and the depth count type.
package tm_cfg_pkg;

	// Width of one depth count.
	// Counts wrap modulo 2**DEPTH_W with no overflow flag.
	parameter int DEPTH_W = 8;

	// Default queue id width.
	// This is the widest level and it sizes the init address.
	parameter int QID_W_DEF = 6;

	// Default connection id width.
	parameter int CID_W_DEF = 4;

	// One depth count, as stored in the depth memories.
	// It is also the value returned to the requester.
	typedef logic [DEPTH_W-1:0] depth_t;

endpackage
